//--- files.f
logic/backEndPkg.sv
logic/stageLink.sv
logic/memStage.sv
logic/sadStage1.sv
logic/sadStage2.sv
logic/writebackStage.sv
logic/sadBackEnd.sv
tb/sadBackEnd_assertions.sv
tb/sadBackEndChecker.sv
tb/sadBackEndTb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = sadBackEndTb
FILELIST  = files.f
BUILDDIR  = obj_dir
LOG       = sim.log
PASSMSG   = Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILDDIR) -f $(FILELIST)

run: compile
	./$(BUILDDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASSMSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation did not pass"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILDDIR) $(LOG)

//--- tb/sadBackEndTb.sv
// Testbench top for the SAD back end
module sadBackEndTb
        import backEndPkg::*;
();

        //////////////////////////////////////////////////
        // Run geometry
        //////////////////////////////////////////////////

        localparam int clkPeriod = 40;
        localparam int resetCycles = 16;
        localparam int numTests = 6;
        localparam int slotsPerTest = 48;
        localparam int marginCycles = 64;
        // Reset plus every issued slot plus drain room
        localparam int watchdogCycles = resetCycles + numTests * slotsPerTest + marginCycles;

        // Instruction kinds
        localparam int kindBubble = 0;
        localparam int kindAlu = 1;
        localparam int kindStore = 2;
        localparam int kindLoad = 3;
        localparam int kindJal = 4;
        localparam int kindSad = 5;

        logic Clk;
        logic rst;
        logic inValid;
        ctrlBundle inCtrl;
        logic [dataWidth-1:0] inAluResult;
        logic [dataWidth-1:0] inOperand;
        logic [dataWidth-1:0] inPcPlus4;
        logic wbValid;
        logic wbRegWrite;
        logic [regAddrWidth-1:0] wbReg;
        logic [dataWidth-1:0] wbData;

        // Expected record, driven together with the DUT inputs
        logic expValid;
        logic expRegWrite;
        logic [regAddrWidth-1:0] expReg;
        logic [dataWidth-1:0] expData;
        logic expLast;
        logic [7:0] expTest;

        int testsPassed;
        int testsFailed;
        int totalErrors;

        // Model state
        integer seed;
        logic [7:0] curTest;
        logic [dataWidth-1:0] modelMem [memDepth];
        logic [7:0] writtenAddrs [$];

        sadBackEnd dut0 (
                .Clk         (Clk),
                .rst         (rst),
                .inValid     (inValid),
                .inCtrl      (inCtrl),
                .inAluResult (inAluResult),
                .inOperand   (inOperand),
                .inPcPlus4   (inPcPlus4),
                .wbValid     (wbValid),
                .wbRegWrite  (wbRegWrite),
                .wbReg       (wbReg),
                .wbData      (wbData)
        );

        sadBackEndChecker check0 (
                .Clk         (Clk),
                .rst         (rst),
                .wbValid     (wbValid),
                .wbRegWrite  (wbRegWrite),
                .wbReg       (wbReg),
                .wbData      (wbData),
                .expValid    (expValid),
                .expRegWrite (expRegWrite),
                .expReg      (expReg),
                .expData     (expData),
                .expLast     (expLast),
                .expTest     (expTest),
                .testsPassed (testsPassed),
                .testsFailed (testsFailed),
                .totalErrors (totalErrors)
        );

        always #(clkPeriod / 2) Clk = ~Clk;

        //////////////////////////////////////////////////
        // Reference model
        //////////////////////////////////////////////////

        // Uniform pick in 0..n-1
        function automatic int randomBelow(input int n);
                return ($random(seed) & 32'h7fff_ffff) % n;
        endfunction

        // Sum of |a[i] - b[i]| over the four bytes
        function automatic logic [31:0] absDiffSum(input logic [31:0] a, input logic [31:0] b);
                logic [31:0] total;
                logic [7:0] x;
                logic [7:0] y;
                total = 0;
                for (int i = 0; i < 4; i++) begin
                        x = a[8*i +: 8];
                        y = b[8*i +: 8];
                        total = total + ((x > y) ? 32'(x - y) : 32'(y - x));
                end
                return total;
        endfunction

        // Writeback priority, jal over SAD over load over ALU
        function automatic logic [31:0] expectedWriteback(input ctrlBundle c,
                        input logic [31:0] alu, input logic [31:0] operand,
                        input logic [31:0] pc);
                logic [31:0] word;
                word = modelMem[alu[9:2]];
                if (c.jal) return pc;
                if (c.sadOp) return absDiffSum(word, operand);
                if (c.memToReg) return word;
                return alu;
        endfunction

        //////////////////////////////////////////////////
        // Stimulus
        //////////////////////////////////////////////////

        // One slot on the falling edge, expected record alongside
        task automatic issue(input logic valid, input ctrlBundle c, input logic [31:0] alu,
                        input logic [31:0] operand, input logic last);
                logic [31:0] pc;
                pc = $random(seed);
                @(negedge Clk);
                inValid     = valid;
                inCtrl      = c;
                inAluResult = alu;
                inOperand   = operand;
                inPcPlus4   = pc;
                expValid    = valid;
                expRegWrite = valid & c.regWrite;
                expReg      = c.writeReg;
                // Model reads before it writes, same as the memory
                expData     = expectedWriteback(c, alu, operand, pc);
                expLast     = last;
                expTest     = curTest;
                if (valid && c.memWrite) begin
                        modelMem[alu[9:2]] = operand;
                end
        endtask

        // Bubble carrying junk control and data
        task automatic issueBubble(input logic last);
                logic [31:0] r;
                r = $random(seed);
                issue(1'b0, r[8:0], $random(seed), $random(seed), last);
        endtask

        task automatic issueKind(input int kind, input logic noWrite, input logic last);
                ctrlBundle c;
                logic [31:0] alu;
                logic [31:0] r;
                r = $random(seed);
                alu = $random(seed);
                c = '0;
                c.writeReg = r[4:0];
                case (kind)
                        kindAlu: c.regWrite = 1'b1;
                        kindStore: begin
                                c.memWrite = 1'b1;
                                writtenAddrs.push_back(alu[9:2]);
                        end
                        kindLoad: begin
                                c.memRead  = 1'b1;
                                c.memToReg = 1'b1;
                                c.regWrite = 1'b1;
                                alu[9:2] = writtenAddrs[randomBelow(writtenAddrs.size())];
                        end
                        kindJal: begin
                                // Other sources set on purpose, jal must win
                                c.jal      = 1'b1;
                                c.regWrite = 1'b1;
                                c.memRead  = r[5];
                                c.memToReg = r[6];
                                c.sadOp    = r[7];
                        end
                        default: begin
                                c.sadOp    = 1'b1;
                                c.regWrite = 1'b1;
                                c.memToReg = r[6];
                                alu[9:2] = writtenAddrs[randomBelow(writtenAddrs.size())];
                        end
                endcase
                if (noWrite) c.regWrite = 1'b0;
                issue(1'b1, c, alu, $random(seed), last);
        endtask

        function automatic int chooseKind(input int testNum, input int slot);
                int kind;
                case (testNum)
                        1: kind = kindBubble;
                        2: kind = kindAlu;
                        3: kind = (slot < slotsPerTest / 2) ? kindStore : kindLoad;
                        4: kind = kindJal;
                        5: kind = (randomBelow(4) == 0) ? kindStore : kindSad;
                        default: kind = kindAlu + randomBelow(5);
                endcase
                // Never read a word that was not stored
                if ((kind == kindLoad || kind == kindSad) && writtenAddrs.size() == 0)
                        kind = kindStore;
                return kind;
        endfunction

        task automatic runTest(input int testNum);
                int kind;
                logic last;
                curTest = 8'(testNum);
                for (int s = 0; s < slotsPerTest; s++) begin
                        last = (s == slotsPerTest - 1);
                        kind = chooseKind(testNum, s);
                        if (kind == kindBubble || randomBelow(4) == 0) begin
                                issueBubble(last);
                        end else begin
                                issueKind(kind, testNum == 6, last);
                        end
                end
        endtask

        //////////////////////////////////////////////////
        // Run control and watchdog
        //////////////////////////////////////////////////

        initial begin
                seed        = 32'h28f8;
                curTest     = 8'd0;
                Clk         = 1'b0;
                rst         = 1'b1;
                inValid     = 1'b0;
                inCtrl      = '0;
                inAluResult = '0;
                inOperand   = '0;
                inPcPlus4   = '0;
                expValid    = 1'b0;
                expRegWrite = 1'b0;
                expReg      = '0;
                expData     = '0;
                expLast     = 1'b0;
                expTest     = 8'd0;
                repeat (resetCycles) @(posedge Clk);
                @(negedge Clk);
                rst = 1'b0;
                for (int t = 1; t <= numTests; t++) begin
                        runTest(t);
                end
                // Flush until the checker has closed every test
                while (testsPassed + testsFailed < numTests) begin
                        issueBubble(1'b0);
                end
                $display("Summary: %0d tests passed, %0d tests failed, %0d mismatches",
                         testsPassed, testsFailed, totalErrors);
                if (testsFailed == 0 && totalErrors == 0) begin
                        $display("Test completed successfully");
                end else begin
                        $display("Test failed");
                end
                $finish;
        end

        initial begin
                #(watchdogCycles * clkPeriod);
                $display("Timeout: tests still running after %0d clock cycles", watchdogCycles);
                $display("Test failed");
                $finish;
        end

endmodule

//--- tb/sadBackEndChecker.sv
// Scoreboard on the DUT writeback ports
module sadBackEndChecker
        import backEndPkg::*;
(
        input  logic Clk,
        input  logic rst,
        input  logic wbValid,
        input  logic wbRegWrite,
        input  logic [regAddrWidth-1:0] wbReg,
        input  logic [dataWidth-1:0] wbData,
        input  logic expValid,
        input  logic expRegWrite,
        input  logic [regAddrWidth-1:0] expReg,
        input  logic [dataWidth-1:0] expData,
        input  logic expLast,
        input  logic [7:0] expTest,
        output int testsPassed,
        output int testsFailed,
        output int totalErrors
);

        typedef struct packed {
                logic last;
                logic valid;
                logic regWrite;
                logic [regAddrWidth-1:0] writeReg;
                logic [dataWidth-1:0] data;
                logic [7:0] testNum;
        } expRecord;

        // One record per slot, oldest first
        expRecord pending [$];
        expRecord rec;
        int testErrors;
        int testSlots;

        initial begin
                testsPassed = 0;
                testsFailed = 0;
                totalErrors = 0;
                testErrors  = 0;
                testSlots   = 0;
        end

        function automatic string testName(input logic [7:0] n);
                case (n)
                        8'd1: return "idle";
                        8'd2: return "alu";
                        8'd3: return "store-load";
                        8'd4: return "jal";
                        8'd5: return "sad";
                        8'd6: return "mixed no-write";
                        default: return "unknown";
                endcase
        endfunction

        task automatic reportMismatch(input string signal, input logic [31:0] expected,
                        input logic [31:0] actual);
                $display("FAILED at %0t: %s expected 0x%0h, got 0x%0h",
                         $time, signal, expected, actual);
                testErrors++;
                totalErrors++;
        endtask

        //////////////////////////////////////////////////
        // Capture at the edge where the DUT samples
        //////////////////////////////////////////////////

        always @(posedge Clk) begin
                if (!rst) begin
                        pending.push_back({expLast, expValid, expRegWrite, expReg, expData,
                                           expTest});
                end
        end

        //////////////////////////////////////////////////
        // Compare mid-cycle, after the fourth register
        //////////////////////////////////////////////////

        always @(negedge Clk) begin
                if (pending.size() >= 4) begin
                        rec = pending.pop_front();
                        testSlots++;
                        if (wbValid !== rec.valid)
                                reportMismatch("wbValid", 32'(rec.valid), 32'(wbValid));
                        if (wbRegWrite !== rec.regWrite)
                                reportMismatch("wbRegWrite", 32'(rec.regWrite), 32'(wbRegWrite));
                        // Register and data only mean something in a live slot
                        if (rec.valid) begin
                                if (wbReg !== rec.writeReg)
                                        reportMismatch("wbReg", 32'(rec.writeReg), 32'(wbReg));
                                if (wbData !== rec.data)
                                        reportMismatch("wbData", rec.data, wbData);
                        end
                        if (rec.last) begin
                                if (testErrors == 0) begin
                                        testsPassed++;
                                        $display("PASS test %0d %s, %0d slots checked",
                                                 rec.testNum, testName(rec.testNum), testSlots);
                                end else begin
                                        testsFailed++;
                                        $display("FAIL test %0d %s, %0d mismatches in %0d slots",
                                                 rec.testNum, testName(rec.testNum),
                                                 testErrors, testSlots);
                                end
                                testErrors = 0;
                                testSlots  = 0;
                        end
                end
        end

endmodule

//--- tb/sadBackEnd_assertions.sv
// Port-level protocol checks on the back end
module sadBackEndAssertions (
        input  logic Clk,
        input  logic rst,
        input  logic inValid,
        input  logic wbValid,
        input  logic wbRegWrite
);

        // Output slot empty one cycle into reset
        resetEmptiesOutput: assert property (
                @(posedge Clk) rst |=> !wbValid
        ) else $error("wbValid still high one cycle after reset");

        // No register write from a bubble
        writeNeedsValid: assert property (
                @(posedge Clk) disable iff (rst) wbRegWrite |-> wbValid
        ) else $error("wbRegWrite high while wbValid is low");

        // Fixed four-cycle latency, any reset cancels it
        fixedLatency: assert property (
                @(posedge Clk) disable iff (rst) inValid |-> ##4 wbValid
        ) else $error("valid input did not reach wbValid four cycles later");

endmodule

bind sadBackEnd sadBackEndAssertions assert0 (
        .Clk        (Clk),
        .rst        (rst),
        .inValid    (inValid),
        .wbValid    (wbValid),
        .wbRegWrite (wbRegWrite)
);

//--- logic/sadBackEnd.sv
// Back half of the pipeline: MEM, SAD1, SAD2, WB
module sadBackEnd
        import backEndPkg::*;
(
        input  logic Clk,
        input  logic rst,
        // Slot handed over by execute
        input  logic inValid,
        input  ctrlBundle inCtrl,
        input  logic [dataWidth-1:0] inAluResult,
        input  logic [dataWidth-1:0] inOperand,
        input  logic [dataWidth-1:0] inPcPlus4,
        // Register-write request, four cycles later
        output logic wbValid,
        output logic wbRegWrite,
        output logic [regAddrWidth-1:0] wbReg,
        output logic [dataWidth-1:0] wbData
);

        //////////////////////////////////////////////////
        // Inter-stage links
        //////////////////////////////////////////////////

        // Loaded word and operand
        stageLink memToSad1 ();

        // Packed differences and loaded word
        stageLink sad1ToSad2 ();

        // SAD sum and loaded word
        stageLink sad2ToWb ();

        //////////////////////////////////////////////////
        // Stage instances
        //////////////////////////////////////////////////

        memStage mem0 (
                .Clk         (Clk),
                .rst         (rst),
                .inValid     (inValid),
                .inCtrl      (inCtrl),
                .inAluResult (inAluResult),
                .inOperand   (inOperand),
                .inPcPlus4   (inPcPlus4),
                .outLink     (memToSad1)
        );

        sadStage1 sad1 (
                .Clk     (Clk),
                .rst     (rst),
                .inLink  (memToSad1),
                .outLink (sad1ToSad2)
        );

        sadStage2 sad2 (
                .Clk     (Clk),
                .rst     (rst),
                .inLink  (sad1ToSad2),
                .outLink (sad2ToWb)
        );

        // Output registers live in here
        writebackStage wb0 (
                .Clk        (Clk),
                .rst        (rst),
                .inLink     (sad2ToWb),
                .wbValid    (wbValid),
                .wbRegWrite (wbRegWrite),
                .wbReg      (wbReg),
                .wbData     (wbData)
        );

endmodule

//--- logic/writebackStage.sv
// Last stage, picks the register-write value
module writebackStage
        import backEndPkg::*;
(
        input  logic Clk,
        input  logic rst,
        stageLink.sink inLink,
        output logic wbValid,
        output logic wbRegWrite,
        output logic [regAddrWidth-1:0] wbReg,
        output logic [dataWidth-1:0] wbData
);

        //////////////////////////////////////////////////
        // Writeback source select
        //////////////////////////////////////////////////

        logic [dataWidth-1:0] wbSel;

        // Priority jal, then SAD, then load, then ALU
        always_comb begin
                if (inLink.ctrl.jal) begin
                        wbSel = inLink.pcPlus4;
                end else if (inLink.ctrl.sadOp) begin
                        wbSel = inLink.dataA;
                end else if (inLink.ctrl.memToReg) begin
                        wbSel = inLink.dataB;
                end else begin
                        wbSel = inLink.aluResult;
                end
        end

        //////////////////////////////////////////////////
        // Output registers
        //////////////////////////////////////////////////

        always_ff @(posedge Clk) begin
                if (rst) begin
                        wbValid    <= 1'b0;
                        wbRegWrite <= 1'b0;
                        wbReg      <= '0;
                        wbData     <= '0;
                end else begin
                        wbValid    <= inLink.valid;
                        // Bubbles never write the register file
                        wbRegWrite <= inLink.valid & inLink.ctrl.regWrite;
                        wbReg      <= inLink.ctrl.writeReg;
                        wbData     <= wbSel;
                end
        end

endmodule

//--- logic/sadStage2.sv
// Second SAD stage, reduces four differences to one sum
module sadStage2
        import backEndPkg::*;
(
        input  logic Clk,
        input  logic rst,
        stageLink.sink inLink,
        stageLink.source outLink
);

        //////////////////////////////////////////////////
        // Adder tree over the packed differences
        //////////////////////////////////////////////////

        // Wide enough for 4 x 255
        logic [sadSumWidth-1:0] sadSum;

        always_comb begin
                sadSum = '0;
                for (int i = 0; i < dataWidth / 8; i++) begin
                        // Each byte zero-extended before the add
                        sadSum = sadSum + sadSumWidth'(inLink.dataA[8*i +: 8]);
                end
        end

        //////////////////////////////////////////////////
        // Slot control register
        //////////////////////////////////////////////////

        always_ff @(posedge Clk) begin
                if (rst) begin
                        outLink.valid <= 1'b0;
                        outLink.ctrl  <= '0;
                end else begin
                        outLink.valid <= inLink.valid;
                        outLink.ctrl  <= inLink.ctrl;
                end
        end

        //////////////////////////////////////////////////
        // Payload register
        //////////////////////////////////////////////////

        always_ff @(posedge Clk) begin
                outLink.aluResult <= inLink.aluResult;
                outLink.pcPlus4   <= inLink.pcPlus4;
                // Sum padded to a full word
                outLink.dataA     <= dataWidth'(sadSum);
                // Loaded word passes through untouched
                outLink.dataB     <= inLink.dataB;
        end

endmodule

//--- logic/sadStage1.sv
// Pipeline register after memory, first half of the SAD datapath
module sadStage1
        import backEndPkg::*;
(
        input  logic Clk,
        input  logic rst,
        stageLink.sink inLink,
        stageLink.source outLink
);

        //////////////////////////////////////////////////
        // Byte-wise absolute differences
        //////////////////////////////////////////////////

        // Byte i holds |loaded[i] - operand[i]|
        logic [dataWidth-1:0] byteDiffs;

        always_comb begin
                byteDiffs = '0;
                for (int i = 0; i < dataWidth / 8; i++) begin
                        // Subtract the smaller byte from the larger
                        if (inLink.dataA[8*i +: 8] > inLink.dataB[8*i +: 8]) begin
                                byteDiffs[8*i +: 8] = inLink.dataA[8*i +: 8]
                                                      - inLink.dataB[8*i +: 8];
                        end else begin
                                byteDiffs[8*i +: 8] = inLink.dataB[8*i +: 8]
                                                      - inLink.dataA[8*i +: 8];
                        end
                end
        end

        //////////////////////////////////////////////////
        // Control moving from memory into SAD1
        //////////////////////////////////////////////////

        always_ff @(posedge Clk) begin
                if (rst) begin
                        outLink.valid <= 1'b0;
                        outLink.ctrl  <= '0;
                end else begin
                        outLink.valid <= inLink.valid;
                        outLink.ctrl  <= inLink.ctrl;
                end
        end

        //////////////////////////////////////////////////
        // Data moving from memory into SAD1
        //////////////////////////////////////////////////

        always_ff @(posedge Clk) begin
                outLink.aluResult <= inLink.aluResult;
                outLink.pcPlus4   <= inLink.pcPlus4;
                // Packed differences for the adder stage
                outLink.dataA     <= byteDiffs;
                // Loaded word still needed for writeback
                outLink.dataB     <= inLink.dataA;
        end

endmodule

//--- logic/memStage.sv
// Memory stage, first clocked stage of the back end
module memStage
        import backEndPkg::*;
(
        input  logic Clk,
        input  logic rst,
        input  logic inValid,
        input  ctrlBundle inCtrl,
        input  logic [dataWidth-1:0] inAluResult,
        input  logic [dataWidth-1:0] inOperand,
        input  logic [dataWidth-1:0] inPcPlus4,
        stageLink.source outLink
);

        //////////////////////////////////////////////////
        // Data memory and addressing
        //////////////////////////////////////////////////

        // Local word memory, no reset on contents
        logic [dataWidth-1:0] dataMem [memDepth];

        // Word address from the byte address
        logic [memAddrWidth-1:0] wordAddr;

        // Qualified store and read strobes
        logic storeEn;
        logic readEn;

        assign wordAddr = inAluResult[memAddrWidth+1:2];

        // Bubbles never touch the memory
        assign storeEn = inValid & inCtrl.memWrite;

        // SAD also fetches its word from memory
        assign readEn = inValid & (inCtrl.memRead | inCtrl.sadOp);

        //////////////////////////////////////////////////
        // Memory write port
        //////////////////////////////////////////////////

        // Store lands at the sampling edge
        // A load one cycle later reads the new word
        always_ff @(posedge Clk) begin
                if (storeEn) begin
                        dataMem[wordAddr] <= inOperand;
                end
        end

        //////////////////////////////////////////////////
        // Synchronous read into the outgoing slot
        //////////////////////////////////////////////////

        // Same-address read and write returns old data
        always_ff @(posedge Clk) begin
                if (readEn) begin
                        outLink.dataA <= dataMem[wordAddr];
                end
        end

        //////////////////////////////////////////////////
        // Slot control register
        //////////////////////////////////////////////////

        always_ff @(posedge Clk) begin
                if (rst) begin
                        outLink.valid <= 1'b0;
                        outLink.ctrl  <= '0;
                end else begin
                        outLink.valid <= inValid;
                        outLink.ctrl  <= inCtrl;
                end
        end

        // Payload travels alongside the read data
        always_ff @(posedge Clk) begin
                outLink.aluResult <= inAluResult;
                outLink.pcPlus4   <= inPcPlus4;
                // Operand kept for the SAD compare
                outLink.dataB     <= inOperand;
        end

endmodule

//--- logic/stageLink.sv
// One pipeline slot moving from one stage to the next
interface stageLink
        import backEndPkg::*;
();

        //////////////////////////////////////////////////
        // Slot contents
        //////////////////////////////////////////////////

        // Low means the slot is a bubble
        logic valid;

        // Control bits of the instruction
        ctrlBundle ctrl;

        // Arithmetic result or memory byte address
        logic [dataWidth-1:0] aluResult;

        // Return address for jal
        logic [dataWidth-1:0] pcPlus4;

        // Meaning of the two data words depends on the link
        logic [dataWidth-1:0] dataA;
        logic [dataWidth-1:0] dataB;

        //////////////////////////////////////////////////
        // Views for the driving and reading stage
        //////////////////////////////////////////////////

        // Stage that registers the slot
        modport source (
                output valid, ctrl, aluResult, pcPlus4, dataA, dataB
        );

        // Stage that consumes the slot
        modport sink (
                input valid, ctrl, aluResult, pcPlus4, dataA, dataB
        );

endinterface

//--- logic/backEndPkg.sv
package backEndPkg;

        //////////////////////////////////////////////////
        // Data path and register file widths
        //////////////////////////////////////////////////

        // Full machine word
        localparam int dataWidth = 32;

        // Register number, 32 architectural registers
        localparam int regAddrWidth = 5;

        //////////////////////////////////////////////////
        // Data memory geometry
        //////////////////////////////////////////////////

        // Words in the local data memory
        localparam int memDepth = 256;

        // Word address, taken from ALU result bits 9..2
        localparam int memAddrWidth = 8;

        // Four byte differences of at most 255 each
        localparam int sadSumWidth = 10;

        //////////////////////////////////////////////////
        // Control bits that ride along with each slot
        //////////////////////////////////////////////////

        typedef struct packed {
                logic memRead;
                logic memWrite;
                // Loaded word goes to the register file
                logic memToReg;
                logic regWrite;
                // Link value wins over every other source
                logic jal;
                // Motion estimation SAD instruction
                logic sadOp;
                logic [regAddrWidth-1:0] writeReg;
        } ctrlBundle;

endpackage
